//--- hw/board_pkg.sv
package board_pkg;

    // clock division, kept small so simulation stays short.
    localparam int MIC_SCK_DIV    = 4;      // clk cycles per half period of sck.
    localparam int TM_CLK_DIV     = 2;      // clk cycles per half period of the panel clock.
    localparam int REFRESH_CYCLES = 4000;

    typedef logic signed [23:0] sample_t;
    typedef logic [15:0]        level_t;    // upper 16 bits of |sample|.
    typedef logic [7:0]         seg_t;      // bit 0 is segment a, bit 7 the decimal point.
    typedef logic [7:0]         keys_t;

    typedef logic [5:0]                        mic_slot_t;
    typedef logic [$clog2(MIC_SCK_DIV)-1:0]    mic_div_t;
    typedef logic [$clog2(TM_CLK_DIV)-1:0]     tm_div_t;
    typedef logic [$clog2(REFRESH_CYCLES)-1:0] refresh_cnt_t;
    typedef logic [4:0]                        tm_byte_idx_t;

    localparam mic_div_t     MIC_DIV_LAST = mic_div_t'(MIC_SCK_DIV - 1);
    localparam tm_div_t      TM_DIV_LAST  = tm_div_t'(TM_CLK_DIV - 1);
    localparam refresh_cnt_t REFRESH_LOAD = refresh_cnt_t'(REFRESH_CYCLES - 1);

    // left channel data slots, one bit after the ws falling edge.
    localparam mic_slot_t MIC_MSB_SLOT = 6'd1;
    localparam mic_slot_t MIC_LSB_SLOT = 6'd24;

    localparam logic [7:0] TM_CMD_WRITE      = 8'h40;   // data write, auto increment.
    localparam logic [7:0] TM_CMD_ADDR       = 8'hC0;   // start at address 0.
    localparam logic [7:0] TM_CMD_DISPLAY_ON = 8'h8F;   // display on, full brightness.
    localparam logic [7:0] TM_CMD_READ       = 8'h42;   // key scan read.

    // index of the last byte in the address and read transactions.
    localparam tm_byte_idx_t TM_ADDR_LAST = 5'd16;
    localparam tm_byte_idx_t TM_READ_LAST = 5'd4;

    typedef struct packed {
        logic [7:0] led;
        seg_t       digit7;
        seg_t       digit6;
        seg_t       digit5;
        seg_t       digit4;
        seg_t       digit3;
        seg_t       digit2;
        seg_t       digit1;
        seg_t       digit0;
    } panel_frame_t;

    typedef enum logic [2:0] {
        TM_IDLE,
        TM_START,
        TM_LOW,
        TM_HIGH,
        TM_STOP,
        TM_GAP
    } tm_state_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_SEND,
        CTRL_WAIT
    } ctrl_state_e;

endpackage

//--- hw/refresh_tick_gen.sv
`timescale 1ns/1ps

module refresh_tick_gen
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    board_pkg::refresh_cnt_t cnt;

    // first tick lands REFRESH_CYCLES cycles after reset is released.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt  <= board_pkg::REFRESH_LOAD;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= board_pkg::REFRESH_LOAD;    // reload for the next period.
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- hw/i2s_mic_rx.sv
`timescale 1ns/1ps

module i2s_mic_rx
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mic_sd,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               sample_valid,
    output board_pkg::sample_t sample
);

    board_pkg::mic_div_t  div_cnt;
    board_pkg::mic_slot_t slot_cnt;
    board_pkg::sample_t   shift_q;
    logic [1:0]           last_pipe;
    logic                 half_done;
    logic                 sck_rise;
    logic                 sck_fall;
    logic                 data_slot;

    assign half_done = (div_cnt == board_pkg::MIC_DIV_LAST);
    assign sck_rise  = half_done && !mic_sck;
    assign sck_fall  = half_done && mic_sck;

    // ws is low for slots 0..31 (left) and high for 32..63.
    assign mic_ws = slot_cnt[5];

    assign data_slot = (slot_cnt >= board_pkg::MIC_MSB_SLOT)
                    && (slot_cnt <= board_pkg::MIC_LSB_SLOT);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt      <= '0;
            mic_sck      <= 1'b0;
            slot_cnt     <= '0;
            last_pipe    <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;

            if (half_done)
                mic_sck <= ~mic_sck;

            // a new slot starts on every sck falling edge, ws moves with it.
            if (sck_fall)
                slot_cnt <= slot_cnt + 1'b1;

            last_pipe    <= {last_pipe[0], sck_rise && (slot_cnt == board_pkg::MIC_LSB_SLOT)};
            sample_valid <= last_pipe[1];   // two cycles after the last bit.
        end
    end

    always_ff @(posedge clk)
    begin
        // msb first, sampled on the rising edge of sck.
        if (sck_rise && data_slot)
            shift_q <= {shift_q[22:0], mic_sd};

        if (last_pipe[1])
            sample <= shift_q;
    end

endmodule

//--- hw/tm1638_driver.sv
`timescale 1ns/1ps

module tm1638_driver
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    frame_valid,
    input  board_pkg::panel_frame_t frame,
    input  logic                    tm_dio_in,
    output logic                    credit_return,
    output board_pkg::keys_t        keys,
    output logic                    tm_clk,
    output logic                    tm_stb,
    output logic                    tm_dio_out,
    output logic                    tm_dio_oe
);

    board_pkg::tm_state_e     state;
    board_pkg::panel_frame_t  frame_q;
    board_pkg::seg_t [7:0]    digits;
    board_pkg::tm_div_t       div_cnt;
    board_pkg::tm_byte_idx_t  byte_idx;
    board_pkg::tm_byte_idx_t  last_byte;
    board_pkg::tm_byte_idx_t  data_idx;
    board_pkg::keys_t         key_acc;
    logic [1:0]               txn;          // write, address, display on, read.
    logic [2:0]               bit_cnt;
    logic [7:0]               tx_byte;
    logic [7:0]               rx_shift;
    logic [1:0]               rd_idx;
    logic                     half_done;
    logic                     reading;

    assign half_done = (div_cnt == board_pkg::TM_DIV_LAST);
    assign digits    = {frame_q.digit7, frame_q.digit6, frame_q.digit5, frame_q.digit4,
                        frame_q.digit3, frame_q.digit2, frame_q.digit1, frame_q.digit0};
    assign data_idx  = byte_idx - 1'b1;     // byte after the command byte.
    assign rd_idx    = data_idx[1:0];
    assign reading   = (txn == 2'd3) && (byte_idx != '0);

    // byte to shift out for the current transaction and position.
    always_comb
    begin
        last_byte = '0;
        case (txn)
            2'd0: tx_byte = board_pkg::TM_CMD_WRITE;
            2'd1:
            begin
                last_byte = board_pkg::TM_ADDR_LAST;
                if (byte_idx == '0)
                    tx_byte = board_pkg::TM_CMD_ADDR;
                else if (data_idx[0])
                    tx_byte = {7'b0, frame_q.led[data_idx[3:1]]};  // odd address, one led.
                else
                    tx_byte = digits[data_idx[3:1]];
            end
            2'd2: tx_byte = board_pkg::TM_CMD_DISPLAY_ON;
            default:
            begin
                last_byte = board_pkg::TM_READ_LAST;
                tx_byte   = board_pkg::TM_CMD_READ;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state         <= board_pkg::TM_IDLE;
            div_cnt       <= '0;
            txn           <= '0;
            byte_idx      <= '0;
            bit_cnt       <= '0;
            tm_clk        <= 1'b0;
            tm_stb        <= 1'b1;
            tm_dio_out    <= 1'b0;
            tm_dio_oe     <= 1'b0;
            credit_return <= 1'b0;
            keys          <= '0;
        end
        else
        begin
            credit_return <= 1'b0;
            div_cnt       <= (state == board_pkg::TM_IDLE || half_done) ? '0 : div_cnt + 1'b1;

            case (state)
                board_pkg::TM_IDLE:
                    if (frame_valid)
                    begin
                        txn      <= '0;
                        byte_idx <= '0;
                        bit_cnt  <= '0;
                        tm_stb   <= 1'b0;
                        state    <= board_pkg::TM_START;
                    end
                board_pkg::TM_START:
                    if (half_done)
                        state <= board_pkg::TM_LOW;
                board_pkg::TM_LOW:
                begin
                    // data moves only while the serial clock is low.
                    tm_dio_out <= tx_byte[bit_cnt];
                    tm_dio_oe  <= !reading;
                    if (half_done)
                    begin
                        tm_clk <= 1'b1;
                        state  <= board_pkg::TM_HIGH;
                    end
                end
                board_pkg::TM_HIGH:
                    if (half_done)
                    begin
                        tm_clk  <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;      // wraps to 0 after bit 7.
                        if (bit_cnt == 3'd7 && byte_idx == last_byte)
                            state <= board_pkg::TM_STOP;
                        else
                        begin
                            if (bit_cnt == 3'd7)
                                byte_idx <= byte_idx + 1'b1;
                            state <= board_pkg::TM_LOW;
                        end
                    end
                board_pkg::TM_STOP:
                    if (half_done)
                    begin
                        tm_stb    <= 1'b1;
                        tm_dio_oe <= 1'b0;
                        if (txn == 2'd3)
                        begin
                            credit_return <= 1'b1;  // slot is free again.
                            keys          <= key_acc;
                            state         <= board_pkg::TM_IDLE;
                        end
                        else
                        begin
                            txn      <= txn + 1'b1;
                            byte_idx <= '0;
                            state    <= board_pkg::TM_GAP;
                        end
                    end
                board_pkg::TM_GAP:
                    if (half_done)
                    begin
                        tm_stb <= 1'b0;
                        state  <= board_pkg::TM_START;
                    end
                default:
                    state <= board_pkg::TM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == board_pkg::TM_IDLE && frame_valid)
            frame_q <= frame;

        // lsb first, taken as the serial clock rises.
        if (state == board_pkg::TM_LOW && half_done && reading)
            rx_shift <= {tm_dio_in, rx_shift[7:1]};

        // each read byte holds two keys, in bits 0 and 4.
        if (state == board_pkg::TM_HIGH && half_done && reading && bit_cnt == 3'd7)
        begin
            key_acc[{rd_idx, 1'b0}] <= rx_shift[0];
            key_acc[{rd_idx, 1'b1}] <= rx_shift[4];
        end
    end

endmodule

//--- hw/level_display_ctrl.sv
`timescale 1ns/1ps

module level_display_ctrl
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tick,
    input  logic                    sample_valid,
    input  board_pkg::sample_t      sample,
    input  logic                    credit_return,
    input  board_pkg::keys_t        keys,
    output logic                    frame_valid,
    output board_pkg::panel_frame_t frame
);

    board_pkg::ctrl_state_e state;
    board_pkg::level_t      peak;
    board_pkg::level_t      shown;
    board_pkg::level_t      mag;
    logic [23:0]            abs_val;
    logic [1:0]             credits;
    logic                   pending;
    logic                   hold;
    logic                   key0_q;
    logic                   send;

    function automatic board_pkg::seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_seg = 8'h3F;
            4'h1: hex_seg = 8'h06;
            4'h2: hex_seg = 8'h5B;
            4'h3: hex_seg = 8'h4F;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'h6D;
            4'h6: hex_seg = 8'h7D;
            4'h7: hex_seg = 8'h07;
            4'h8: hex_seg = 8'h7F;
            4'h9: hex_seg = 8'h6F;
            4'hA: hex_seg = 8'h77;
            4'hB: hex_seg = 8'h7C;
            4'hC: hex_seg = 8'h39;
            4'hD: hex_seg = 8'h5E;
            4'hE: hex_seg = 8'h79;
            default: hex_seg = 8'h71;
        endcase
    endfunction

    assign abs_val = sample[23] ? -sample : sample;     // full scale negative still fits.
    assign mag     = abs_val[23:8];

    // a refresh goes out only with a credit in hand.
    assign send        = (state == board_pkg::CTRL_IDLE) && (credits != '0) && (tick || pending);
    assign frame_valid = (state == board_pkg::CTRL_SEND);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= board_pkg::CTRL_IDLE;
            credits <= 2'd1;
            pending <= 1'b0;
        end
        else
        begin
            case (state)
                board_pkg::CTRL_IDLE: if (send) state <= board_pkg::CTRL_SEND;
                board_pkg::CTRL_SEND: state <= board_pkg::CTRL_WAIT;
                board_pkg::CTRL_WAIT: if (credit_return) state <= board_pkg::CTRL_IDLE;
                default:              state <= board_pkg::CTRL_IDLE;
            endcase

            if (frame_valid && !credit_return)
                credits <= credits - 1'b1;
            else if (credit_return && !frame_valid)
                credits <= credits + 1'b1;

            // extra ticks fold into one pending refresh.
            if (send)
                pending <= 1'b0;
            else if (tick)
                pending <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            peak   <= '0;
            shown  <= '0;
            hold   <= 1'b0;
            key0_q <= 1'b0;
        end
        else
        begin
            if (send)
            begin
                if (!hold)
                    shown <= peak;
                peak <= sample_valid ? mag : '0;
            end
            else if (sample_valid && mag > peak)
                peak <= mag;

            // key 0 press between two reports flips hold.
            if (credit_return)
            begin
                key0_q <= keys[0];
                if (keys[0] && !key0_q)
                    hold <= ~hold;
            end
        end
    end

    always_comb
    begin
        frame.digit0 = hex_seg(shown[15:12]);
        frame.digit1 = hex_seg(shown[11:8]);
        frame.digit2 = hex_seg(shown[7:4]);
        frame.digit3 = hex_seg(shown[3:0]);
        frame.digit4 = '0;
        frame.digit5 = '0;
        frame.digit6 = '0;
        frame.digit7 = '0;
        for (int i = 0; i < 8; i++)
            frame.led[i] = |(shown >> (8 + i));     // lit at 2**(8+i) and above.
    end

endmodule

//--- hw/board_top.sv
`timescale 1ns/1ps

module board_top
(
    input  logic clk,
    input  logic rst_n,
    input  logic mic_sd,
    input  logic tm_dio_in,
    output logic mic_sck,
    output logic mic_ws,
    output logic tm_clk,
    output logic tm_stb,
    output logic tm_dio_out,
    output logic tm_dio_oe
);

    logic                    tick;
    logic                    sample_valid;
    board_pkg::sample_t      sample;
    logic                    frame_valid;
    board_pkg::panel_frame_t frame;
    logic                    credit_return;
    board_pkg::keys_t        keys;

    refresh_tick_gen i_tick_gen
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tick  ( tick  )
    );

    i2s_mic_rx i_microphone
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .mic_sd       ( mic_sd       ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .sample_valid ( sample_valid ),
        .sample       ( sample       )
    );

    level_display_ctrl i_ctrl
    (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .tick          ( tick          ),
        .sample_valid  ( sample_valid  ),
        .sample        ( sample        ),
        .credit_return ( credit_return ),
        .keys          ( keys          ),
        .frame_valid   ( frame_valid   ),
        .frame         ( frame         )
    );

    // the data pad itself sits outside, in the vendor io ring.
    tm1638_driver i_tm1638
    (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .frame_valid   ( frame_valid   ),
        .frame         ( frame         ),
        .tm_dio_in     ( tm_dio_in     ),
        .credit_return ( credit_return ),
        .keys          ( keys          ),
        .tm_clk        ( tm_clk        ),
        .tm_stb        ( tm_stb        ),
        .tm_dio_out    ( tm_dio_out    ),
        .tm_dio_oe     ( tm_dio_oe     )
    );

endmodule

//--- tb/tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top;

    localparam int FRAME_CYCLES = 1000;     // generous bound on one panel frame.
    localparam int TEST_FRAMES  = 14;       // panel frames that the tests wait for.
    localparam int CYCLE_LIMIT  = (TEST_FRAMES + 2) * board_pkg::REFRESH_CYCLES;

    // command byte and bit count of each transaction in a frame.
    localparam logic [7:0] TXN_CMD [4] = '{board_pkg::TM_CMD_WRITE, board_pkg::TM_CMD_ADDR,
                                           board_pkg::TM_CMD_DISPLAY_ON, board_pkg::TM_CMD_READ};
    localparam int TXN_BITS [4] = '{8, 136, 8, 40};

    // segments a to g in bits 0 to 6.
    localparam logic [7:0] HEX_SEG [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                                           8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};

    logic clk;
    logic rst_n;
    logic mic_sd;
    logic tm_dio_in;
    logic mic_sck;
    logic mic_ws;
    logic tm_clk;
    logic tm_stb;
    logic tm_dio_out;
    logic tm_dio_oe;

    int          cycle;
    int          errors;
    int          checks;
    logic [31:0] rnd_state;

    board_pkg::sample_t mic_word;           // word that the next left half carries.
    logic [23:0]        cur_word;
    int                 mic_slot;
    logic               ws_prev;
    int                 words_sent;
    logic               noise_on;

    board_pkg::keys_t panel_keys;
    int               bit_pos;
    int               byte_n;
    logic [1:0]       txn_idx;
    int               frames_seen;
    int               frame_done_cyc;
    logic [7:0]       shift_byte;
    logic [7:0]       cmd_q;
    logic [7:0]       cap_cmd [4];
    logic [7:0]       cap_data [16];
    logic [7:0]       last_cmd [4];
    logic [7:0]       last_data [16];

    board_top dut_i
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .mic_sd     ( mic_sd     ),
        .tm_dio_in  ( tm_dio_in  ),
        .mic_sck    ( mic_sck    ),
        .mic_ws     ( mic_ws     ),
        .tm_clk     ( tm_clk     ),
        .tm_stb     ( tm_stb     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // upper 16 bits of the absolute sample value.
    function automatic board_pkg::level_t magnitude(input board_pkg::sample_t s);
        int v;
        v = int'(s);
        if (v < 0)
            v = -v;
        return board_pkg::level_t'(v >> 8);
    endfunction

    function automatic board_pkg::seg_t hex_pattern(input logic [3:0] nib);
        return HEX_SEG[nib];
    endfunction

    // read byte n carries key 2n in bit 0 and key 2n+1 in bit 4.
    function automatic logic key_bit(input int pos);
        board_pkg::keys_t kb;
        kb = panel_keys >> (2 * (pos / 8));
        case (pos % 8)
            0:       key_bit = kb[0];
            4:       key_bit = kb[1];
            default: key_bit = 1'b0;
        endcase
    endfunction

    task automatic note_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: failed with %0d errors", name, errors - errors_before);
    endtask

    task automatic wait_frame();
        int n;
        n = frames_seen;
        while (frames_seen == n)
            @(posedge clk);
        #1;
    endtask

    task automatic wait_word();
        int n;
        n = words_sent;
        while (words_sent == n)
            @(posedge clk);
        #1;
    endtask

    // microphone: sd moves on sck falling edges, MSB one slot after ws falls.
    always @(negedge mic_sck)
    begin
        #1;
        if (!rst_n)
        begin
            mic_slot = 0;
            ws_prev  = 1'b0;
        end
        else
        begin
            mic_slot = (ws_prev && !mic_ws) ? 0 : mic_slot + 1;
            ws_prev  = mic_ws;
            if (!mic_ws && mic_slot == 1)
            begin
                if (noise_on)
                begin
                    rnd_state = xorshift(rnd_state);
                    mic_word  = rnd_state[23:0];
                end
                cur_word   = mic_word;
                words_sent = words_sent + 1;
            end
            else if (!mic_ws && mic_slot >= 2 && mic_slot <= 24)
                cur_word = {cur_word[22:0], 1'b0};
            mic_sd = (!mic_ws && mic_slot >= 1 && mic_slot <= 24) ? cur_word[23] : 1'b0;
        end
    end

    always @(negedge tm_stb)
    begin
        bit_pos = 0;
        cmd_q   = '0;
    end

    // panel samples the data line as its clock rises, LSB first.
    always @(posedge tm_clk)
    begin
        if (!tm_stb)
        begin
            shift_byte = {tm_dio_out, shift_byte[7:1]};
            bit_pos    = bit_pos + 1;
            if (cmd_q == board_pkg::TM_CMD_READ && tm_dio_oe)
                note_error("the FPGA drives the panel data line during the key read");
            if (bit_pos % 8 == 0)
            begin
                byte_n = bit_pos / 8 - 1;
                if (byte_n == 0)
                    cmd_q = shift_byte;
                else if (cmd_q == board_pkg::TM_CMD_ADDR && byte_n <= 16)
                    cap_data[4'(byte_n - 1)] = shift_byte;
            end
        end
    end

    always @(negedge tm_clk)
    begin
        if (!tm_stb && cmd_q == board_pkg::TM_CMD_READ && bit_pos < 40)
        begin
            #1;
            tm_dio_in = key_bit(bit_pos - 8);
        end
    end

    always @(posedge tm_stb)
    begin
        if (bit_pos > 0)
        begin
            checks = checks + 1;
            if (cmd_q != TXN_CMD[txn_idx] || bit_pos != TXN_BITS[txn_idx])
                note_error($sformatf("panel transaction %0d out of order: command %h, %0d bits",
                                     txn_idx, cmd_q, bit_pos));
            cap_cmd[txn_idx] = cmd_q;
            bit_pos          = 0;
            if (txn_idx == 2'd3)
            begin
                last_cmd       = cap_cmd;
                last_data      = cap_data;
                frame_done_cyc = cycle;
                frames_seen    = frames_seen + 1;
            end
            txn_idx = txn_idx + 1'b1;   // wraps to the write command.
        end
    end

    task automatic check_frame(input string name, input board_pkg::level_t level);
        logic [7:0] exp_data [16];
        logic [7:0] bar;
        logic [3:0] nib;
        int         i;
        for (i = 0; i < 8; i++)
        begin
            bar[i]            = (int'(level) >= (1 << (8 + i)));
            nib               = 4'(level >> (12 - 4 * i));
            exp_data[2*i]     = (i < 4) ? hex_pattern(nib) : 8'h00;
            exp_data[2*i + 1] = {7'b0, bar[i]};
        end
        for (i = 0; i < 16; i++)
        begin
            checks = checks + 1;
            if (last_data[i] != exp_data[i])
                note_error($sformatf("%s: address %0d is %h, expected %h",
                                     name, i, last_data[i], exp_data[i]));
        end
        for (i = 0; i < 4; i++)
        begin
            checks = checks + 1;
            if (last_cmd[i] != TXN_CMD[i])
                note_error($sformatf("%s: command %0d is %h, expected %h",
                                     name, i, last_cmd[i], TXN_CMD[i]));
        end
    endtask

    task automatic check_reset_state();
        int e0;
        e0     = errors;
        checks = checks + 1;
        if (tm_stb !== 1'b1 || tm_clk !== 1'b0 || tm_dio_oe !== 1'b0
            || mic_sck !== 1'b0 || mic_ws !== 1'b0)
            note_error($sformatf("reset pins stb %b clk %b oe %b sck %b ws %b",
                                 tm_stb, tm_clk, tm_dio_oe, mic_sck, mic_ws));
        rst_n = 1'b1;
        wait_frame();
        check_frame("first frame", 16'h0000);
        report_test("reset state", e0);
    endtask

    task automatic show_constant_levels();
        board_pkg::sample_t s;
        int                 e0;
        e0       = errors;
        s        = 24'sh123456;
        mic_word = s;
        wait_frame();
        check_frame("positive sample", magnitude(s));
        s        = -24'sh654300;    // louder, so the window maximum is this one.
        mic_word = s;
        wait_frame();
        check_frame("negative sample", magnitude(s));
        report_test("level display", e0);
    endtask

    task automatic track_random_peak();
        board_pkg::sample_t s;
        board_pkg::level_t  top;
        int                 e0;
        int                 k;
        e0       = errors;
        mic_word = '0;
        wait_frame();               // flushes the loud words still in flight.
        top = 16'h0005;
        for (k = 0; k < 4; k++)
        begin
            rnd_state = xorshift(rnd_state);
            s         = rnd_state[23:0];
            mic_word  = s;
            if (magnitude(s) > top)
                top = magnitude(s);
            wait_word();
        end
        mic_word = 24'sh000500;
        wait_frame();
        check_frame("random peak", top);
        wait_frame();
        check_frame("quiet after peak", 16'h0005);
        report_test("peak and bar", e0);
    endtask

    task automatic toggle_hold();
        int e0;
        e0         = errors;
        panel_keys = 8'h01;
        wait_frame();               // key 0 reported down, hold turns on.
        check_frame("hold press", 16'h0005);
        panel_keys = 8'h00;
        mic_word   = 24'sh7F0000;
        wait_frame();
        check_frame("held level", 16'h0005);
        wait_frame();
        check_frame("held under loud input", 16'h0005);
        panel_keys = 8'h01;
        wait_frame();
        check_frame("release press", 16'h0005);
        panel_keys = 8'h00;
        wait_frame();
        check_frame("live again", magnitude(24'sh7F0000));
        report_test("hold mode", e0);
    endtask

    task automatic pace_frames();
        int e0;
        int k;
        int prev;
        int gap;
        e0       = errors;
        noise_on = 1'b1;
        prev     = frame_done_cyc;
        for (k = 0; k < 3; k++)
        begin
            wait_frame();
            gap    = frame_done_cyc - prev;
            checks = checks + 1;
            if (gap < board_pkg::REFRESH_CYCLES - FRAME_CYCLES
                || gap > board_pkg::REFRESH_CYCLES + FRAME_CYCLES)
                note_error($sformatf("frame %0d ended %0d cycles after the previous one", k, gap));
            prev = frame_done_cyc;
        end
        noise_on = 1'b0;
        report_test("frame ordering", e0);
    endtask

    initial
    begin
        rst_n       = 1'b0;
        mic_sd      = 1'b0;
        tm_dio_in   = 1'b0;
        mic_word    = '0;
        cur_word    = '0;
        mic_slot    = 0;
        ws_prev     = 1'b0;     // ws is low out of reset.
        noise_on    = 1'b0;
        panel_keys  = '0;
        rnd_state   = 32'd3;
        bit_pos     = 0;
        txn_idx     = '0;
        frames_seen = 0;
        words_sent  = 0;
        errors      = 0;
        checks      = 0;
        repeat (16) @(posedge clk);
        #1;
        check_reset_state();
        show_constant_levels();
        track_random_peak();
        toggle_hold();
        pace_frames();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sources.f
hw/board_pkg.sv
hw/refresh_tick_gen.sv
hw/i2s_mic_rx.sv
hw/tm1638_driver.sv
hw/level_display_ctrl.sv
hw/board_top.sv
tb/tb_board_top.sv

//--- Makefile
SIM  = obj_dir/Vtb_board_top
SRCS = $(shell cat sources.f)

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary -j 0 -f sources.f --top-module tb_board_top -o Vtb_board_top

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
